// File: Bender.yml
package:
  name: memtest_driver

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/memtest_mem_pkg.sv
      - hw/memtest_ctrl_pkg.sv
      - hw/lfsr_lane.sv
      - hw/memtest_pattern_gen.sv
      - hw/memtest_addr_gen.sv
      - hw/memtest_sequencer.sv
      - hw/memtest_checker.sv
      - hw/memtest_driver.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/mem_model.sv
      - testbench/tb_memtest_driver.sv

// File: build.f
+incdir+hw
hw/memtest_mem_pkg.sv
hw/memtest_ctrl_pkg.sv
hw/lfsr_lane.sv
hw/memtest_pattern_gen.sv
hw/memtest_addr_gen.sv
hw/memtest_sequencer.sv
hw/memtest_checker.sv
hw/memtest_driver.sv
testbench/mem_model.sv
testbench/tb_memtest_driver.sv

// File: hw/lfsr_lane.sv
`timescale 1ns/1ps

module lfsr_lane #(
  parameter logic [7:0] SEED = 8'h01
) (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       advance,
  input  logic       load,
  input  logic [7:0] ldata,
  output logic [7:0] data
);

  logic feedback;

  // taps 8, 6, 5, 4 give a maximal length sequence
  assign feedback = data[7] ^ data[5] ^ data[4] ^ data[3];

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      data <= SEED;
    end
    else if (load)
    begin
      // load wins over a step in the same cycle
      data <= ldata;
    end
    else if (advance)
    begin
      data <= {data[6:0], feedback};
    end
  end

endmodule

// File: hw/memtest_addr_gen.sv
`timescale 1ns/1ps
`include "memtest_params.svh"

module memtest_addr_gen (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       step,
  input  logic                       clear,
  output memtest_mem_pkg::mem_addr_t addr,
  output logic                       last
);

  localparam logic [`MT_COL_W-1:0]  COL_STEP  = `MT_COL_W'(`MT_COL_STEP);
  localparam logic [`MT_COL_W-1:0]  COL_LIMIT = `MT_COL_W'(`MT_MAX_COL);
  localparam logic [`MT_ROW_W-1:0]  ROW_LIMIT = `MT_ROW_W'(`MT_MAX_ROW);
  localparam logic [`MT_BANK_W-1:0] BANK_LIMIT = `MT_BANK_W'(`MT_MAX_BANK);
  localparam logic [`MT_CS_W-1:0]   CS_LIMIT  = `MT_CS_W'(`MT_MAX_CS);

  assign last = (addr.col == COL_LIMIT) && (addr.row == ROW_LIMIT) &&
                (addr.bank == BANK_LIMIT) && (addr.cs == CS_LIMIT);

  // column fastest, then row, bank, chip select
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      addr <= '0;
    end
    else if (clear)
    begin
      addr <= '0;
    end
    else if (step)
    begin
      if (addr.col == COL_LIMIT)
      begin
        addr.col <= '0;
        if (addr.row == ROW_LIMIT)
        begin
          addr.row <= '0;
          if (addr.bank == BANK_LIMIT)
          begin
            addr.bank <= '0;
            addr.cs   <= (addr.cs == CS_LIMIT) ? '0 : addr.cs + 1'b1;
          end
          else
          begin
            addr.bank <= addr.bank + 1'b1;
          end
        end
        else
        begin
          addr.row <= addr.row + 1'b1;
        end
      end
      else
      begin
        addr.col <= addr.col + COL_STEP;
      end
    end
  end

  // limit has to be a multiple of the step or the wrap is missed
  assert property (@(posedge clk) disable iff (!reset_n) addr.col <= COL_LIMIT);

endmodule

// File: hw/memtest_checker.sv
`timescale 1ns/1ps
`include "memtest_params.svh"

module memtest_checker (
  input  logic                        clk,
  input  logic                        reset_n,
  input  memtest_mem_pkg::mem_rsp_t   rsp,
  input  memtest_mem_pkg::mem_data_t  expected,
  output memtest_mem_pkg::lane_mask_t pnf_per_byte,
  output logic                        pnf_persist
);

  memtest_mem_pkg::lane_mask_t lane_eq;
  memtest_mem_pkg::lane_mask_t eq_q;
  memtest_mem_pkg::lane_mask_t lane_pass;
  logic                        valid_q;
  logic                        seen;
  logic                        seen_q;
  logic                        failed;

  // byte compare against the regenerated pattern
  always_comb
  begin
    for (int i = 0; i < `MT_LANES; i++)
    begin
      lane_eq[i] = (rsp.data[8*i +: 8] == expected[8*i +: 8]);
    end
  end

  // --------------------
  // compare pipeline
  // --------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      eq_q         <= '1;
      valid_q      <= 1'b0;
      lane_pass    <= '1;
      seen         <= 1'b0;
      pnf_per_byte <= '1;
      seen_q       <= 1'b0;
    end
    else
    begin
      eq_q    <= lane_eq;
      valid_q <= rsp.valid;
      // flags only follow checked beats
      if (valid_q)
      begin
        lane_pass <= eq_q;
        seen      <= 1'b1;
      end
      // output register for the lane flags
      pnf_per_byte <= lane_pass;
      seen_q       <= seen;
    end
  end

  // sticky fail, cleared only by reset
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      failed      <= 1'b0;
      pnf_persist <= 1'b0;
    end
    else
    begin
      if (seen_q && !(&pnf_per_byte))
      begin
        failed <= 1'b1;
      end
      pnf_persist <= seen_q && (&pnf_per_byte) && !failed;
    end
  end

endmodule

// File: hw/memtest_ctrl_pkg.sv
`include "memtest_params.svh"

package memtest_ctrl_pkg;

  // pass sequencing
  typedef enum logic [2:0] {
    IDLE,
    WRITE_FIRST,
    WRITE_NEXT,
    READ,
    DRAIN,
    DONE
  } memtest_state_t;

  // complete is a single cycle pulse at the end of each pass
  typedef struct packed {
    logic writing;
    logic reading;
    logic complete;
  } memtest_status_t;

endpackage

// File: hw/memtest_driver.sv
`timescale 1ns/1ps

module memtest_driver (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              local_ready,
  input  memtest_mem_pkg::mem_rsp_t         local_rsp,
  output memtest_mem_pkg::mem_cmd_t         local_cmd,
  output memtest_mem_pkg::mem_data_t        local_wdata,
  output memtest_mem_pkg::lane_mask_t       pnf_per_byte,
  output logic                              pnf_persist,
  output memtest_ctrl_pkg::memtest_status_t test_status
);

  logic addr_step;
  logic addr_clear;
  logic last;
  logic wbeat;
  logic pass_start;
  logic reload;

  memtest_sequencer i_sequencer (
    .clk         (clk),
    .reset_n     (reset_n),
    .local_ready (local_ready),
    .rdata_valid (local_rsp.valid),
    .last        (last),
    .cmd_write   (local_cmd.write_req),
    .cmd_read    (local_cmd.read_req),
    .burstbegin  (local_cmd.burstbegin),
    .addr_step   (addr_step),
    .addr_clear  (addr_clear),
    .wbeat       (wbeat),
    .pass_start  (pass_start),
    .reload      (reload),
    .status      (test_status)
  );

  memtest_addr_gen i_addr_gen (
    .clk     (clk),
    .reset_n (reset_n),
    .step    (addr_step),
    .clear   (addr_clear),
    .addr    (local_cmd.addr),
    .last    (last)
  );

  // write data and expected read data share one generator
  memtest_pattern_gen i_pattern_gen (
    .clk         (clk),
    .reset_n     (reset_n),
    .wbeat       (wbeat),
    .rdata_valid (local_rsp.valid),
    .pass_start  (pass_start),
    .reload      (reload),
    .data        (local_wdata)
  );

  memtest_checker i_checker (
    .clk          (clk),
    .reset_n      (reset_n),
    .rsp          (local_rsp),
    .expected     (local_wdata),
    .pnf_per_byte (pnf_per_byte),
    .pnf_persist  (pnf_persist)
  );

endmodule

// File: hw/memtest_mem_pkg.sv
`include "memtest_params.svh"

package memtest_mem_pkg;

  // one location on the local port
  typedef struct packed {
    logic [`MT_CS_W-1:0]   cs;
    logic [`MT_BANK_W-1:0] bank;
    logic [`MT_ROW_W-1:0]  row;
    logic [`MT_COL_W-1:0]  col;
  } mem_addr_t;

  typedef logic [`MT_DATA_W-1:0] mem_data_t;

  // one flag per byte lane
  typedef logic [`MT_LANES-1:0] lane_mask_t;

  // request side, held while local_ready is low
  typedef struct packed {
    logic      write_req;
    logic      read_req;
    logic      burstbegin;
    mem_addr_t addr;
  } mem_cmd_t;

  // read return beat
  typedef struct packed {
    logic      valid;
    mem_data_t data;
  } mem_rsp_t;

endpackage

// File: hw/memtest_params.svh
`ifndef MEMTEST_PARAMS_SVH
`define MEMTEST_PARAMS_SVH

// local port data path
`define MT_DATA_W 128
`define MT_LANES 16

// address field widths
`define MT_CS_W 1
`define MT_BANK_W 2
`define MT_ROW_W 14
`define MT_COL_W 10

// burst shape, column advance per burst
`define MT_BURST_LEN 2
`define MT_COL_STEP 4

// inclusive upper limits of the tested range
`define MT_MAX_COL 16
`define MT_MAX_ROW 3
`define MT_MAX_BANK 3
`define MT_MAX_CS 1

`define MT_OUTSTANDING_W 8

// lane n starts from base + n * step
`define MT_LFSR_SEED_BASE 1
`define MT_LFSR_SEED_STEP 10

`endif

// File: hw/memtest_pattern_gen.sv
`timescale 1ns/1ps
`include "memtest_params.svh"

module memtest_pattern_gen (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       wbeat,
  input  logic                       rdata_valid,
  input  logic                       pass_start,
  input  logic                       reload,
  output memtest_mem_pkg::mem_data_t data
);

  memtest_mem_pkg::mem_data_t reload_word;
  logic                       advance;

  // one step per accepted write beat or returned read beat
  assign advance = wbeat | rdata_valid;

  // word at the start of the pass, restored for the read phase
  always_ff @(posedge clk)
  begin
    if (pass_start)
    begin
      reload_word <= data;
    end
  end

  // --------------------
  // byte lanes
  // --------------------
  for (genvar g = 0; g < `MT_LANES; g++)
  begin : g_lane
    lfsr_lane #(
      .SEED (8'(`MT_LFSR_SEED_BASE + g * `MT_LFSR_SEED_STEP))
    ) i_lane (
      .clk     (clk),
      .reset_n (reset_n),
      .advance (advance),
      .load    (reload),
      .ldata   (reload_word[8*g +: 8]),
      .data    (data[8*g +: 8])
    );
  end

endmodule

// File: hw/memtest_sequencer.sv
`timescale 1ns/1ps
`include "memtest_params.svh"

module memtest_sequencer (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              local_ready,
  input  logic                              rdata_valid,
  input  logic                              last,
  output logic                              cmd_write,
  output logic                              cmd_read,
  output logic                              burstbegin,
  output logic                              addr_step,
  output logic                              addr_clear,
  output logic                              wbeat,
  output logic                              pass_start,
  output logic                              reload,
  output memtest_ctrl_pkg::memtest_status_t status
);

  localparam int BEAT_W = ($clog2(`MT_BURST_LEN) > 0) ? $clog2(`MT_BURST_LEN) : 1;
  localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`MT_BURST_LEN - 1);
  localparam logic [`MT_OUTSTANDING_W-1:0] RD_BEATS = `MT_OUTSTANDING_W'(`MT_BURST_LEN);

  memtest_ctrl_pkg::memtest_state_t state;
  logic [BEAT_W-1:0]                beat_cnt;
  logic [`MT_OUTSTANDING_W-1:0]     rd_outstanding;
  logic                             write_acc;
  logic                             read_acc;
  logic                             burst_end;

  assign write_acc = cmd_write & local_ready;
  assign read_acc  = cmd_read & local_ready;
  assign burst_end = write_acc && (state == memtest_ctrl_pkg::WRITE_NEXT) &&
                     (beat_cnt == LAST_BEAT);

  assign wbeat      = write_acc;
  // address moves after the final write beat or after each read
  assign addr_step  = burst_end | read_acc;
  assign addr_clear = addr_step & last;
  // read phase replays the pattern from the start of the pass
  assign reload     = burst_end & last;
  assign pass_start = (state == memtest_ctrl_pkg::IDLE) || (state == memtest_ctrl_pkg::DONE);

  assign status.writing  = (state == memtest_ctrl_pkg::WRITE_FIRST) ||
                           (state == memtest_ctrl_pkg::WRITE_NEXT);
  assign status.reading  = (state == memtest_ctrl_pkg::READ) ||
                           (state == memtest_ctrl_pkg::DRAIN);
  assign status.complete = (state == memtest_ctrl_pkg::DONE);

  // --------------------
  // command FSM
  // --------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state      <= memtest_ctrl_pkg::IDLE;
      cmd_write  <= 1'b0;
      cmd_read   <= 1'b0;
      burstbegin <= 1'b0;
      beat_cnt   <= '0;
    end
    else
    begin
      case (state)
        memtest_ctrl_pkg::IDLE, memtest_ctrl_pkg::DONE:
        begin
          cmd_write  <= 1'b1;
          burstbegin <= 1'b1;
          state      <= memtest_ctrl_pkg::WRITE_FIRST;
        end
        memtest_ctrl_pkg::WRITE_FIRST:
        begin
          if (write_acc)
          begin
            burstbegin <= 1'b0;
            beat_cnt   <= beat_cnt + 1'b1;
            state      <= memtest_ctrl_pkg::WRITE_NEXT;
          end
        end
        memtest_ctrl_pkg::WRITE_NEXT:
        begin
          if (burst_end)
          begin
            beat_cnt   <= '0;
            burstbegin <= 1'b1;
            if (last)
            begin
              cmd_write <= 1'b0;
              cmd_read  <= 1'b1;
              state     <= memtest_ctrl_pkg::READ;
            end
            else
            begin
              state <= memtest_ctrl_pkg::WRITE_FIRST;
            end
          end
          else if (write_acc)
          begin
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        memtest_ctrl_pkg::READ:
        begin
          // one request per burst, burstbegin stays high
          if (read_acc && last)
          begin
            cmd_read   <= 1'b0;
            burstbegin <= 1'b0;
            state      <= memtest_ctrl_pkg::DRAIN;
          end
        end
        memtest_ctrl_pkg::DRAIN:
        begin
          if (rd_outstanding == '0)
          begin
            state <= memtest_ctrl_pkg::DONE;
          end
        end
        default:
        begin
          state <= memtest_ctrl_pkg::IDLE;
        end
      endcase
    end
  end

  // beats still owed by the memory
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      rd_outstanding <= '0;
    end
    else
    begin
      rd_outstanding <= rd_outstanding + (read_acc ? RD_BEATS : '0) -
                        `MT_OUTSTANDING_W'(rdata_valid);
    end
  end

  // memory returns nothing that was not requested
  assert property (@(posedge clk) disable iff (!reset_n)
    rdata_valid |-> (rd_outstanding != '0));

  // request held across a stall
  assert property (@(posedge clk) disable iff (!reset_n)
    (cmd_write || cmd_read) && !local_ready |=> $stable({cmd_write, cmd_read, burstbegin}));

endmodule

// File: testbench/mem_model.sv
`timescale 1ns/1ps
`include "memtest_params.svh"

module mem_model #(
  parameter int FAULT_READ = 200,
  parameter int FAULT_BEAT = 1,
  parameter int FAULT_LANE = 5
) (
  input  logic                       clk,
  input  logic                       reset_n,
  input  memtest_mem_pkg::mem_cmd_t  cmd,
  input  memtest_mem_pkg::mem_data_t wdata,
  output logic                       ready,
  output memtest_mem_pkg::mem_rsp_t  rsp,
  output logic                       fault_active
);

  // storage keyed by burst address and beat
  memtest_mem_pkg::mem_data_t store [int];
  memtest_mem_pkg::mem_data_t ret_data [$];
  logic                       ret_fault [$];
  int                         ret_due [$];
  memtest_mem_pkg::mem_rsp_t  rsp_next;
  memtest_mem_pkg::mem_data_t word;
  logic                       fault_next;
  logic                       ready_next;
  logic                       flip;
  integer                     seed;
  int                         cycle;
  int                         wbeat;
  int                         reads;
  int                         due;
  int                         key;

  initial
  begin
    seed         = 32'h9c4dc39b;
    cycle        = 0;
    wbeat        = 0;
    reads        = 0;
    ready        = 1'b0;
    rsp          = '0;
    fault_active = 1'b0;
    forever
    begin
      @(posedge clk);
      cycle++;
      rsp_next   = '0;
      fault_next = 1'b0;
      ready_next = 1'b0;
      if (!reset_n)
      begin
        ret_data.delete();
        ret_fault.delete();
        ret_due.delete();
      end
      else
      begin
        if (ready && cmd.write_req)
        begin
          wbeat = cmd.burstbegin ? 0 : wbeat + 1;
          store[int'(cmd.addr) * `MT_BURST_LEN + wbeat] = wdata;
        end
        if (ready && cmd.read_req)
        begin
          // first beat 2 to 6 cycles out, never ahead of older beats
          due = cycle + 2 + int'($unsigned($random(seed)) % 5);
          if ((ret_due.size() > 0) && (due <= ret_due[$]))
          begin
            due = ret_due[$] + 1;
          end
          for (int b = 0; b < `MT_BURST_LEN; b++)
          begin
            key  = int'(cmd.addr) * `MT_BURST_LEN + b;
            word = store.exists(key) ? store[key] : '0;
            flip = (reads == FAULT_READ) && (b == FAULT_BEAT);
            if (flip)
            begin
              word[8*FAULT_LANE +: 8] = ~word[8*FAULT_LANE +: 8];
            end
            ret_data.push_back(word);
            ret_fault.push_back(flip);
            ret_due.push_back(due + b);
          end
          reads++;
        end
        if ((ret_due.size() > 0) && (ret_due[0] <= cycle))
        begin
          rsp_next.valid = 1'b1;
          rsp_next.data  = ret_data.pop_front();
          fault_next     = ret_fault.pop_front();
          void'(ret_due.pop_front());
        end
        // roughly one stall cycle in four
        ready_next = (($random(seed) & 3) != 0);
      end
      #2;
      ready        = ready_next;
      rsp          = rsp_next;
      fault_active = fault_next;
    end
  end

endmodule

// File: testbench/tb_memtest_driver.sv
`timescale 1ns/1ps
`include "memtest_params.svh"

module tb_memtest_driver;

  // three passes of about 650 cycles each with stalls
  localparam int CYCLE_LIMIT = 6000;
  localparam int PASSES      = 3;
  localparam int BURSTS      = 160;
  localparam int FAULT_READ  = 200;
  localparam int FAULT_BEAT  = 1;
  localparam int FAULT_LANE  = 5;
  localparam memtest_mem_pkg::lane_mask_t FAULT_MASK = ~(`MT_LANES'(1) << FAULT_LANE);

  logic                              clk;
  logic                              reset_n;
  logic                              local_ready;
  memtest_mem_pkg::mem_rsp_t         local_rsp;
  memtest_mem_pkg::mem_cmd_t         local_cmd;
  memtest_mem_pkg::mem_data_t        local_wdata;
  memtest_mem_pkg::lane_mask_t       pnf_per_byte;
  logic                              pnf_persist;
  memtest_ctrl_pkg::memtest_status_t test_status;
  logic                              fault_active;
  logic                              write_acc;
  logic                              read_acc;
  memtest_mem_pkg::mem_data_t        wr_model;
  memtest_mem_pkg::mem_data_t        rd_model;
  memtest_mem_pkg::mem_addr_t        wr_addr;
  memtest_mem_pkg::mem_addr_t        rd_addr;
  memtest_mem_pkg::lane_mask_t       beat_mask;
  memtest_mem_pkg::lane_mask_t [2:0] mask_pipe;
  logic [2:0]                        valid_pipe;
  int                                wr_beat;
  int                                wr_bursts;
  int                                rd_reqs;
  int                                rd_beats;
  int                                passes;
  int                                fault_age;
  int                                errors;
  int                                cycle_cnt;

  memtest_driver i_memtest_driver (
    .clk          (clk),
    .reset_n      (reset_n),
    .local_ready  (local_ready),
    .local_rsp    (local_rsp),
    .local_cmd    (local_cmd),
    .local_wdata  (local_wdata),
    .pnf_per_byte (pnf_per_byte),
    .pnf_persist  (pnf_persist),
    .test_status  (test_status)
  );

  mem_model #(
    .FAULT_READ (FAULT_READ),
    .FAULT_BEAT (FAULT_BEAT),
    .FAULT_LANE (FAULT_LANE)
  ) i_mem_model (
    .clk          (clk),
    .reset_n      (reset_n),
    .cmd          (local_cmd),
    .wdata        (local_wdata),
    .ready        (local_ready),
    .rsp          (local_rsp),
    .fault_active (fault_active)
  );

  assign write_acc = local_cmd.write_req && local_ready;
  assign read_acc  = local_cmd.read_req && local_ready;

  // --------------------
  // reference model
  // --------------------
  function automatic memtest_mem_pkg::mem_data_t seed_word();
    memtest_mem_pkg::mem_data_t w;
    for (int n = 0; n < `MT_LANES; n++)
    begin
      w[8*n +: 8] = 8'(`MT_LFSR_SEED_BASE + n * `MT_LFSR_SEED_STEP);
    end
    return w;
  endfunction

  // taps 8, 6, 5 and 4 with the shift toward the msb
  function automatic memtest_mem_pkg::mem_data_t lfsr_advance(
    memtest_mem_pkg::mem_data_t w
  );
    logic [7:0] b;
    for (int n = 0; n < `MT_LANES; n++)
    begin
      b           = w[8*n +: 8];
      w[8*n +: 8] = {b[6:0], b[7] ^ b[5] ^ b[4] ^ b[3]};
    end
    return w;
  endfunction

  // column fastest, then row, bank and chip select
  function automatic memtest_mem_pkg::mem_addr_t next_burst_addr(
    memtest_mem_pkg::mem_addr_t a
  );
    memtest_mem_pkg::mem_addr_t n;
    n     = a;
    n.col = a.col + `MT_COL_W'(`MT_COL_STEP);
    if (a.col == `MT_COL_W'(`MT_MAX_COL))
    begin
      n.col = '0;
      n.row = a.row + 1'b1;
      if (a.row == `MT_ROW_W'(`MT_MAX_ROW))
      begin
        n.row  = '0;
        n.bank = a.bank + 1'b1;
        if (a.bank == `MT_BANK_W'(`MT_MAX_BANK))
        begin
          n.bank = '0;
          n.cs   = (a.cs == `MT_CS_W'(`MT_MAX_CS)) ? '0 : a.cs + 1'b1;
        end
      end
    end
    return n;
  endfunction

  task automatic value_mismatch(input string name, input logic [`MT_DATA_W-1:0] expected,
                                input logic [`MT_DATA_W-1:0] actual);
    errors++;
    $display("Error: %s expected %h actual %h", name, expected, actual);
  endtask

  task automatic protocol_violation(input string what);
    errors++;
    $display("%0t ns: %s", $time, what);
  endtask

  always_comb
  begin
    for (int n = 0; n < `MT_LANES; n++)
    begin
      beat_mask[n] = (local_rsp.data[8*n +: 8] == rd_model[8*n +: 8]);
    end
  end

  always @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      wr_model   <= seed_word();
      rd_model   <= '0;
      wr_addr    <= '0;
      rd_addr    <= '0;
      wr_beat    <= 0;
      wr_bursts  <= 0;
      rd_reqs    <= 0;
      rd_beats   <= 0;
      passes     <= 0;
      fault_age  <= 0;
      valid_pipe <= '0;
      mask_pipe  <= '1;
    end
    else
    begin
      if (write_acc)
      begin
        wr_model <= lfsr_advance(wr_model);
        // reads of the pass replay from its first write beat
        if ((wr_bursts == 0) && (wr_beat == 0))
        begin
          rd_model <= wr_model;
        end
        if (wr_beat == `MT_BURST_LEN - 1)
        begin
          wr_beat   <= 0;
          wr_bursts <= wr_bursts + 1;
          wr_addr   <= next_burst_addr(wr_addr);
        end
        else
        begin
          wr_beat <= wr_beat + 1;
        end
      end
      if (read_acc)
      begin
        rd_reqs <= rd_reqs + 1;
        rd_addr <= next_burst_addr(rd_addr);
      end
      if (local_rsp.valid)
      begin
        rd_beats <= rd_beats + 1;
        rd_model <= lfsr_advance(rd_model);
      end
      if (test_status.complete)
      begin
        passes    <= passes + 1;
        wr_bursts <= 0;
        rd_reqs   <= 0;
        rd_beats  <= 0;
      end
      if (fault_active || (fault_age > 0))
      begin
        fault_age <= fault_age + 1;
      end
      // the checker answers three edges after the beat
      valid_pipe <= {valid_pipe[1:0], local_rsp.valid};
      mask_pipe  <= {mask_pipe[1:0], beat_mask};
    end
  end

  // --------------------
  // write side
  // --------------------
  assert property (@(posedge clk) disable iff (!reset_n)
    write_acc |-> (local_wdata == wr_model))
    else value_mismatch("write data", $sampled(wr_model), $sampled(local_wdata));
  assert property (@(posedge clk) disable iff (!reset_n)
    write_acc |-> (local_cmd.addr == wr_addr))
    else value_mismatch("write address", $sampled(wr_addr), $sampled(local_cmd.addr));
  assert property (@(posedge clk) disable iff (!reset_n)
    write_acc |-> (local_cmd.burstbegin == (wr_beat == 0)))
    else value_mismatch("write burstbegin", $sampled(wr_beat == 0),
                        $sampled(local_cmd.burstbegin));
  assert property (@(posedge clk) disable iff (!reset_n)
    write_acc && local_cmd.burstbegin |=> local_cmd.write_req && !local_cmd.burstbegin)
    else protocol_violation("second write beat did not follow the first");
  assert property (@(posedge clk) disable iff (!reset_n)
    test_status.writing |-> local_cmd.write_req)
    else protocol_violation("write_req dropped inside the write phase");
  assert property (@(posedge clk) disable iff (!reset_n)
    write_acc |-> (wr_bursts < BURSTS))
    else protocol_violation("more write bursts in a pass than the range holds");
  assert property (@(posedge clk) disable iff (!reset_n)
    (local_cmd.write_req || local_cmd.read_req) && !local_ready |=> $stable(local_cmd))
    else protocol_violation("command changed while local_ready was low");
  assert property (@(posedge clk) disable iff (!reset_n)
    local_cmd.write_req && !local_ready |=> $stable(local_wdata))
    else protocol_violation("write data changed while local_ready was low");

  // --------------------
  // read side and flags
  // --------------------
  assert property (@(posedge clk) disable iff (!reset_n)
    read_acc |-> (local_cmd.addr == rd_addr))
    else value_mismatch("read address", $sampled(rd_addr), $sampled(local_cmd.addr));
  assert property (@(posedge clk) disable iff (!reset_n)
    read_acc |-> local_cmd.burstbegin && (wr_bursts == BURSTS) && (rd_reqs < BURSTS))
    else protocol_violation("read request out of order or without burstbegin");
  assert property (@(posedge clk) disable iff (!reset_n)
    local_cmd.read_req |-> test_status.reading && !test_status.writing)
    else protocol_violation("status did not show the read phase while reads were issued");
  assert property (@(posedge clk) disable iff (!reset_n)
    test_status.complete |-> (wr_bursts == BURSTS) && (rd_reqs == BURSTS) &&
                             (rd_beats == `MT_BURST_LEN * BURSTS))
    else protocol_violation("complete before the pass had finished");
  assert property (@(posedge clk) disable iff (!reset_n)
    test_status.complete |=> !test_status.complete)
    else protocol_violation("complete held for more than one cycle");
  assert property (@(posedge clk) disable iff (!reset_n)
    local_rsp.valid |-> (beat_mask == (fault_active ? FAULT_MASK : '1)))
    else value_mismatch("read beat lanes", $sampled(fault_active ? FAULT_MASK : '1),
                        $sampled(beat_mask));
  assert property (@(posedge clk) disable iff (!reset_n)
    valid_pipe[2] |-> (pnf_per_byte == mask_pipe[2]))
    else value_mismatch("pnf_per_byte", $sampled(mask_pipe[2]), $sampled(pnf_per_byte));
  assert property (@(posedge clk) disable iff (!reset_n)
    test_status.complete && (passes == 0) |-> pnf_persist && (&pnf_per_byte))
    else protocol_violation("pass flags not set after a clean first pass");
  // falls four edges after the bad beat and never recovers
  assert property (@(posedge clk) disable iff (!reset_n)
    (fault_age >= 4) |-> !pnf_persist)
    else protocol_violation("pnf_persist high after the injected fault");

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #20 clk = ~clk;
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial
  begin
    errors    = 0;
    cycle_cnt = 0;
    reset_n   = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    reset_n = 1'b1;
    #1;
    assert (!local_cmd.write_req && !local_cmd.read_req && !local_cmd.burstbegin)
      else protocol_violation("command not idle after reset");
    assert ((test_status == '0) && !pnf_persist)
      else protocol_violation("status or pnf_persist set after reset");
    assert (pnf_per_byte == '1)
      else value_mismatch("pnf_per_byte after reset", memtest_mem_pkg::lane_mask_t'('1),
                          pnf_per_byte);
    while ((passes < PASSES) && (cycle_cnt < CYCLE_LIMIT))
    begin
      @(posedge clk);
      #1;
    end
    // let the last compares leave the checker pipeline
    repeat (5) @(posedge clk);
    #1;
    if (passes < PASSES)
    begin
      protocol_violation("timeout before three passes completed");
    end
    assert (fault_age > 0)
      else protocol_violation("the read fault was never injected");
    assert (!pnf_persist)
      else protocol_violation("pnf_persist high at the end of the run");
    $display("errors: %0d  passes: %0d  cycles: %0d", errors, passes, cycle_cnt);
    if (errors == 0)
    begin
      $display("Test completed successfully");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
